//--- common/colmix_defines.svh
/*
 * colour mixer sizing constants
 * address widths, layer count and video pipeline depth
 */
`ifndef COLMIX_DEFINES_SVH
`define COLMIX_DEFINES_SVH

// palette word address, 2-bit layer id + 5-bit bank + 4-bit colour
`define COLMIX_PAL_AW 11

// one priority register per layer
`define COLMIX_PRI_AW 2

// brightness level width
`define COLMIX_DIM_W 3

`define COLMIX_NLAYERS 4

// pixel strobes from layer sample to rgb output
`define COLMIX_PIPE_DEPTH 3

`endif

//--- common/colmix_pkg.sv
/*
 * colour mixer types
 * layer pixels and the results of the mixer, palette and dimmer stages
 */
`include "colmix_defines.svh"

package colmix_pkg;

    // layer order also sets the tie break
    typedef enum logic [1:0] {
        LYR_FIX = 2'd0,
        LYR_A   = 2'd1,
        LYR_B   = 2'd2,
        LYR_OBJ = 2'd3
    } layer_id_t;

    // one layer pixel, grp and shd only meaningful for objects
    typedef struct packed {
        logic [1:0] grp;
        logic       shd;
        logic [4:0] bank;
        logic [3:0] color;
    } layer_pxl_t;

    typedef struct packed {
        logic [`COLMIX_PAL_AW-1:0] addr;
        logic                      shd;
        logic                      blank;
    } mix_out_t;

    // 15-bit BGR word split into channels
    typedef struct packed {
        logic [4:0] b;
        logic [4:0] g;
        logic [4:0] r;
        logic       shd;
        logic       blank;
    } pal_out_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

//--- logic/colmix_dpram.sv
/*
 * dual-port synchronous RAM
 * one write port and two registered read ports, stored word set by type
 */
`timescale 1ns/1ps

module colmix_dpram #(
    parameter type word_t = logic [7:0],
    parameter int  aw     = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [aw-1:0] waddr,
    input  logic [aw-1:0] raddr_a,
    input  logic [aw-1:0] raddr_b,
    input  word_t         wdata,
    output word_t         q_a,
    output word_t         q_b
);

    word_t mem [2**aw];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // reads return the old word on a same-cycle write
    always_ff @(posedge clk) begin
        q_a <= mem[raddr_a];
        q_b <= mem[raddr_b];
    end

endmodule

//--- mixer/colmix_prio.sv
/*
 * priority mixer
 * picks the opaque layer with the lowest effective priority and
 * registers its palette address together with shadow and blank
 */
`timescale 1ns/1ps
`include "colmix_defines.svh"

module colmix_prio import colmix_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     lhbl,
    input  logic                     lvbl,
    input  logic                     pcu_we,
    input  logic [`COLMIX_PRI_AW-1:0] pri_addr,
    input  logic [5:0]               pri_data,
    input  layer_pxl_t               fix,
    input  layer_pxl_t               lyra,
    input  layer_pxl_t               lyrb,
    input  layer_pxl_t               obj,
    output mix_out_t                 mix,
    output logic [5:0]               pri_q
);

    layer_pxl_t                 lyr [`COLMIX_NLAYERS];
    logic [5:0]                 pri_r [`COLMIX_NLAYERS];
    logic [6:0]                 eff [`COLMIX_NLAYERS];
    logic [`COLMIX_NLAYERS-1:0] pri_vld;
    logic                       rd_vld;
    logic [5:0]                 ram_q;
    layer_id_t                  win_id;
    logic [6:0]                 win_pri;
    logic                       win_any;

    assign lyr[LYR_FIX] = fix;
    assign lyr[LYR_A]   = lyra;
    assign lyr[LYR_B]   = lyrb;
    assign lyr[LYR_OBJ] = obj;

    // register file for cpu read-back, port b is spare
    colmix_dpram #(
        .word_t ( logic [5:0]    ),
        .aw     ( `COLMIX_PRI_AW )
    ) u_prireg (
        .clk     ( clk      ),
        .we      ( pcu_we   ),
        .waddr   ( pri_addr ),
        .raddr_a ( pri_addr ),
        .raddr_b ( '0       ),
        .wdata   ( pri_data ),
        .q_a     ( ram_q    ),
        .q_b     (          )
    );

    // flop copy so all four values are visible at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `COLMIX_NLAYERS; i++) begin
                pri_r[i] <= '0;
            end
            pri_vld <= '0;
            rd_vld  <= 1'b0;
        end else begin
            rd_vld <= pri_vld[pri_addr];
            if (pcu_we) begin
                pri_r[pri_addr]   <= pri_data;
                pri_vld[pri_addr] <= 1'b1;
            end
        end
    end

    // unwritten registers read back as their reset value
    assign pri_q = rd_vld ? ram_q : 6'd0;

    // object group adds steps of 8
    always_comb begin
        for (int i = 0; i < `COLMIX_NLAYERS; i++) begin
            eff[i] = {1'b0, pri_r[i]};
        end
        eff[LYR_OBJ] = {1'b0, pri_r[LYR_OBJ]} + {2'b00, obj.grp, 3'b000};
    end

    // strict compare in ascending order, ties stay with the lower id
    always_comb begin
        win_id  = LYR_FIX;
        win_pri = '1;
        win_any = 1'b0;
        for (int i = 0; i < `COLMIX_NLAYERS; i++) begin
            if (lyr[i].color != 4'd0 && (!win_any || eff[i] < win_pri)) begin
                win_any = 1'b1;
                win_pri = eff[i];
                win_id  = layer_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix.addr  <= '0;
            mix.shd   <= 1'b0;
            mix.blank <= 1'b1;
        end else if (pxl_cen) begin
            mix.addr  <= win_any ? {win_id, lyr[win_id].bank, lyr[win_id].color} : '0;
            // shadow follows the object even when it loses
            mix.shd   <= (obj.color != 4'd0) && obj.shd;
            mix.blank <= ~(lhbl & lvbl);
        end
    end

endmodule

//--- mixer/colmix_palette.sv
/*
 * palette stage
 * two byte-lane RAMs holding 15-bit BGR words, CPU write and read-back
 * on one port and the video lookup on the other
 */
`timescale 1ns/1ps
`include "colmix_defines.svh"

module colmix_palette import colmix_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    pal_cs,
    input  logic                    cpu_we,
    input  logic [1:0]              cpu_dsn,
    input  logic [`COLMIX_PAL_AW:1] cpu_addr,
    input  logic [15:0]             cpu_dout,
    input  mix_out_t                mix,
    output logic [15:0]             cpu_din,
    output pal_out_t                pal
);

    logic [1:0]  lane_we;
    logic [15:0] pal_word;

    // active-low data strobes pick the lanes
    assign lane_we = {2{pal_cs & cpu_we}} & ~cpu_dsn;

    colmix_dpram #(
        .word_t ( logic [7:0]    ),
        .aw     ( `COLMIX_PAL_AW )
    ) u_lane_lo (
        .clk     ( clk            ),
        .we      ( lane_we[0]     ),
        .waddr   ( cpu_addr       ),
        .raddr_a ( cpu_addr       ),
        .raddr_b ( mix.addr       ),
        .wdata   ( cpu_dout[7:0]  ),
        .q_a     ( cpu_din[7:0]   ),
        .q_b     ( pal_word[7:0]  )
    );

    colmix_dpram #(
        .word_t ( logic [7:0]    ),
        .aw     ( `COLMIX_PAL_AW )
    ) u_lane_hi (
        .clk     ( clk             ),
        .we      ( lane_we[1]      ),
        .waddr   ( cpu_addr        ),
        .raddr_a ( cpu_addr        ),
        .raddr_b ( mix.addr        ),
        .wdata   ( cpu_dout[15:8]  ),
        .q_a     ( cpu_din[15:8]   ),
        .q_b     ( pal_word[15:8]  )
    );

    // ram data settles one clk after mix, well before the next strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal       <= '0;
            pal.blank <= 1'b1;
        end else if (pxl_cen) begin
            pal.r     <= pal_word[4:0];
            pal.g     <= pal_word[9:5];
            pal.b     <= pal_word[14:10];
            pal.shd   <= mix.shd;
            pal.blank <= mix.blank;
        end
    end

endmodule

//--- mixer/colmix_dimmer.sv
/*
 * dimmer
 * widens each channel to 8 bits, applies brightness and shadow,
 * and forces black outside the active area
 */
`timescale 1ns/1ps
`include "colmix_defines.svh"

module colmix_dimmer import colmix_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic [`COLMIX_DIM_W-1:0] dim,
    input  logic                     shadow_en,
    input  pal_out_t                 pal,
    output rgb_t                     rgb
);

    logic half;
    rgb_t rgb_nx;

    // one channel through expansion, brightness and shadow
    function automatic logic [7:0] shade(
        input logic [4:0]               c,
        input logic [`COLMIX_DIM_W-1:0] lvl,
        input logic                     halve
    );
        logic [7:0]                 e;
        logic [8+`COLMIX_DIM_W-1:0] p;
        logic [7:0]                 s;

        // replicate the top bits so full scale reaches 255
        e = {c, c[4:2]};
        // level 7 multiplies by 8, so the shift gives unity
        p = e * ({1'b0, lvl} + 1'b1);
        s = p[8+`COLMIX_DIM_W-1:`COLMIX_DIM_W];
        if (halve) begin
            s = s >> 1;
        end
        return s;
    endfunction

    assign half = pal.shd & shadow_en;

    always_comb begin
        rgb_nx.r = shade(pal.r, dim, half);
        rgb_nx.g = shade(pal.g, dim, half);
        rgb_nx.b = shade(pal.b, dim, half);
        if (pal.blank) begin
            rgb_nx = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb <= rgb_nx;
        end
    end

endmodule

//--- logic/colmix_top.sv
/*
 * colour mixer top
 * priority mixer, palette lookup and dimmer in three strobe stages,
 * with the CPU port shared between priority and palette
 */
`timescale 1ns/1ps
`include "colmix_defines.svh"

module colmix_top import colmix_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     lhbl,
    input  logic                     lvbl,
    input  logic                     pcu_cs,
    input  logic                     pal_cs,
    input  logic                     cpu_we,
    input  logic [1:0]               cpu_dsn,
    input  logic [`COLMIX_PAL_AW:1]  cpu_addr,
    input  logic [15:0]              cpu_dout,
    input  layer_pxl_t               fix,
    input  layer_pxl_t               lyra,
    input  layer_pxl_t               lyrb,
    input  layer_pxl_t               obj,
    input  logic [`COLMIX_DIM_W-1:0] dim,
    input  logic                     shadow_en,
    output logic [15:0]              cpu_din,
    output logic [7:0]               red,
    output logic [7:0]               green,
    output logic [7:0]               blue
);

    logic        pcu_we;
    logic [5:0]  pri_q;
    logic [15:0] pal_din;
    mix_out_t    mix;
    pal_out_t    pal;
    rgb_t        rgb;

    // priority registers sit on the low byte lane
    assign pcu_we = pcu_cs & cpu_we & ~cpu_dsn[0];

    colmix_prio u_prio (
        .clk      ( clk                      ),
        .rst      ( rst                      ),
        .pxl_cen  ( pxl_cen                  ),
        .lhbl     ( lhbl                     ),
        .lvbl     ( lvbl                     ),
        .pcu_we   ( pcu_we                   ),
        .pri_addr ( cpu_addr[`COLMIX_PRI_AW:1] ),
        .pri_data ( cpu_dout[5:0]            ),
        .fix      ( fix                      ),
        .lyra     ( lyra                     ),
        .lyrb     ( lyrb                     ),
        .obj      ( obj                      ),
        .mix      ( mix                      ),
        .pri_q    ( pri_q                    )
    );

    colmix_palette u_palette (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .pal_cs   ( pal_cs   ),
        .cpu_we   ( cpu_we   ),
        .cpu_dsn  ( cpu_dsn  ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .mix      ( mix      ),
        .cpu_din  ( pal_din  ),
        .pal      ( pal      )
    );

    colmix_dimmer u_dimmer (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .dim       ( dim       ),
        .shadow_en ( shadow_en ),
        .pal       ( pal       ),
        .rgb       ( rgb       )
    );

    assign cpu_din = pal_cs ? pal_din : {10'd0, pri_q};

    assign red   = rgb.r;
    assign green = rgb.g;
    assign blue  = rgb.b;

endmodule

//--- verification/colmix_checker.sv
/*
 * colour mixer checker
 * mirrors the palette and priority registers from the CPU bus, predicts
 * the rgb output of every pixel strobe and compares CPU read-back
 */
`timescale 1ns/1ps
`include "colmix_defines.svh"

module colmix_checker import colmix_pkg::*; (
    input logic                     clk,
    input logic                     rst,
    input logic                     pxl_cen,
    input logic                     lhbl,
    input logic                     lvbl,
    input logic                     pcu_cs,
    input logic                     pal_cs,
    input logic                     cpu_we,
    input logic [1:0]               cpu_dsn,
    input logic [`COLMIX_PAL_AW:1]  cpu_addr,
    input logic [15:0]              cpu_dout,
    input layer_pxl_t               fix,
    input layer_pxl_t               lyra,
    input layer_pxl_t               lyrb,
    input layer_pxl_t               obj,
    input logic [`COLMIX_DIM_W-1:0] dim,
    input logic                     shadow_en,
    input logic [15:0]              cpu_din,
    input logic [7:0]               red,
    input logic [7:0]               green,
    input logic [7:0]               blue
);

    typedef struct packed {
        logic [14:0] word;
        logic        shd;
        logic        blank;
    } exp_t;

    logic [15:0]               pal_m [2**`COLMIX_PAL_AW];
    logic [5:0]                pri_m [`COLMIX_NLAYERS];
    exp_t                      pipe [$];
    logic                      rd_pend;
    logic [`COLMIX_PAL_AW-1:0] rd_addr;
    logic                      rgb_pend;
    rgb_t                      rgb_exp;
    logic                      was_rst;
    int                        errors;
    int                        checks;

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // 5 to 8 bits, then brightness and shadow
    function automatic logic [7:0] scale(input logic [4:0] c, input logic [2:0] lvl,
                                         input logic halve);
        int v;
        v = {c, c[4:2]};
        v = v * (lvl + 1) / 8;
        if (halve) begin
            v = v / 2;
        end
        return v[7:0];
    endfunction

    // lowest effective priority among opaque layers, first one kept on a tie
    function automatic exp_t predict();
        layer_pxl_t l [4];
        int         best;
        int         bp;
        int         ep;
        logic [10:0] addr;
        exp_t       e;
        l[0] = fix;
        l[1] = lyra;
        l[2] = lyrb;
        l[3] = obj;
        best = -1;
        bp = 0;
        for (int i = 0; i < 4; i++) begin
            ep = pri_m[i];
            if (i == 3) begin
                ep = ep + obj.grp * 8;
            end
            if (l[i].color != 0 && (best < 0 || ep < bp)) begin
                best = i;
                bp = ep;
            end
        end
        addr = (best < 0) ? 11'd0 : {best[1:0], l[best].bank, l[best].color};
        e.word = pal_m[addr][14:0];
        e.shd = (obj.color != 0) && obj.shd;
        e.blank = 1'b0;
        return e;
    endfunction

    always @(posedge clk) begin
        exp_t e;
        if (rst) begin
            pipe.delete();
            rd_pend = 1'b0;
            rgb_pend = 1'b0;
            was_rst = 1'b1;
            for (int i = 0; i < `COLMIX_NLAYERS; i++) begin
                pri_m[i] = '0;
            end
        end else begin
            // first clk out of reset
            if (was_rst) begin
                check_val("red", red, 0);
                check_val("green", green, 0);
                check_val("blue", blue, 0);
                check_val("cpu_din", cpu_din, 0);
                was_rst = 1'b0;
            end
            if (rgb_pend) begin
                check_val("red", red, rgb_exp.r);
                check_val("green", green, rgb_exp.g);
                check_val("blue", blue, rgb_exp.b);
                rgb_pend = 1'b0;
            end
            // read data of the previous address, palette or priority by pal_cs
            if (rd_pend) begin
                if (pal_cs) begin
                    check_val("cpu_din", cpu_din, pal_m[rd_addr]);
                end else begin
                    check_val("cpu_din", cpu_din, {10'd0, pri_m[rd_addr[1:0]]});
                end
            end
            rd_pend = !cpu_we;
            rd_addr = cpu_addr;
            if (pal_cs && cpu_we) begin
                if (!cpu_dsn[0]) begin
                    pal_m[cpu_addr][7:0] = cpu_dout[7:0];
                end
                if (!cpu_dsn[1]) begin
                    pal_m[cpu_addr][15:8] = cpu_dout[15:8];
                end
            end
            if (pcu_cs && cpu_we && !cpu_dsn[0]) begin
                pri_m[cpu_addr[2:1]] = cpu_dout[5:0];
            end
            if (pxl_cen) begin
                // dimmer uses dim and shadow_en of the output strobe
                if (pipe.size() == `COLMIX_PIPE_DEPTH - 1) begin
                    e = pipe.pop_front();
                    rgb_exp.r = scale(e.word[4:0], dim, e.shd && shadow_en);
                    rgb_exp.g = scale(e.word[9:5], dim, e.shd && shadow_en);
                    rgb_exp.b = scale(e.word[14:10], dim, e.shd && shadow_en);
                    if (e.blank) begin
                        rgb_exp = '0;
                    end
                end else begin
                    // stages still hold their reset contents
                    rgb_exp = '0;
                end
                rgb_pend = 1'b1;
                e = predict();
                e.blank = !(lhbl && lvbl);
                pipe.push_back(e);
            end
        end
    end

endmodule

//--- verification/colmix_tb.sv
/*
 * colour mixer testbench
 * fills the palette, sets layer priorities and runs a table of
 * layer pixels, blanking and brightness through the DUT
 */
`timescale 1ns/1ps
`include "colmix_defines.svh"

module colmix_tb import colmix_pkg::*; ();

    typedef struct packed {
        layer_pxl_t fix;
        layer_pxl_t lyra;
        layer_pxl_t lyrb;
        layer_pxl_t obj;
        logic       lhbl;
        logic       lvbl;
        logic [2:0] dim;
        logic       shadow_en;
    } stim_t;

    logic                     clk;
    logic                     rst;
    logic                     pxl_cen;
    logic                     lhbl;
    logic                     lvbl;
    logic                     pcu_cs;
    logic                     pal_cs;
    logic                     cpu_we;
    logic [1:0]               cpu_dsn;
    logic [`COLMIX_PAL_AW:1]  cpu_addr;
    logic [15:0]              cpu_dout;
    layer_pxl_t               fix;
    layer_pxl_t               lyra;
    layer_pxl_t               lyrb;
    layer_pxl_t               obj;
    logic [`COLMIX_DIM_W-1:0] dim;
    logic                     shadow_en;
    logic [15:0]              cpu_din;
    logic [7:0]               red;
    logic [7:0]               green;
    logic [7:0]               blue;
    stim_t                    tbl [$];

    colmix_top dut (.*);

    colmix_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // strobe on every second clk
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(negedge clk);
            pxl_cen <= rst ? 1'b0 : ~pxl_cen;
        end
    end

    function automatic layer_pxl_t px(input logic [1:0] grp, input logic shd,
                                      input logic [4:0] bank, input logic [3:0] color);
        return '{grp: grp, shd: shd, bank: bank, color: color};
    endfunction

    task automatic add(input layer_pxl_t f, input layer_pxl_t a, input layer_pxl_t b,
                       input layer_pxl_t o, input logic hb, input logic vb,
                       input logic [2:0] d, input logic se);
        tbl.push_back('{f, a, b, o, hb, vb, d, se});
    endtask

    task automatic cpu_write(input logic [10:0] addr, input logic [15:0] data,
                             input logic [1:0] dsn, input logic to_pal);
        pal_cs = to_pal;
        pcu_cs = !to_pal;
        cpu_we = 1'b1;
        cpu_dsn = dsn;
        cpu_addr = addr;
        cpu_dout = data;
        @(negedge clk);
        pal_cs = 1'b0;
        pcu_cs = 1'b0;
        cpu_we = 1'b0;
        cpu_dsn = 2'b11;
    endtask

    // the select stays on into the next clk, where the data returns
    task automatic cpu_read(input logic [10:0] addr, input logic to_pal);
        pal_cs = to_pal;
        pcu_cs = !to_pal;
        cpu_we = 1'b0;
        cpu_addr = addr;
        @(negedge clk);
    endtask

    task automatic next_strobe();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!pxl_cen && n < 20);
        if (!pxl_cen) begin
            $display("timeout: no pixel strobe within 20 clocks");
            $display("TESTS FAILED");
            $finish;
        end else begin
            @(negedge clk);
        end
    endtask

    initial begin
        logic [10:0] a;
        void'($urandom(32'h7f95));
        rst = 1'b1;
        {lhbl, lvbl, pcu_cs, pal_cs, cpu_we} = '0;
        cpu_dsn = 2'b11;
        cpu_addr = '0;
        cpu_dout = '0;
        {fix, lyra, lyrb, obj} = '0;
        dim = 3'd7;
        shadow_en = 1'b0;
        repeat (10) @(negedge clk);
        rst <= 1'b0;
        repeat (2) @(negedge clk);

        for (int i = 0; i < 2**`COLMIX_PAL_AW; i++) begin
            cpu_write(i[10:0], 16'($urandom()), 2'b00, 1'b1);
        end

        // byte lanes: hi only, lo only, none
        for (int i = 0; i < 8; i++) begin
            a = 11'($urandom());
            cpu_write(a, 16'($urandom()), 2'b01, 1'b1);
            cpu_write(a, 16'($urandom()), 2'b10, 1'b1);
            cpu_write(a, 16'($urandom()), 2'b11, 1'b1);
            cpu_read(a, 1'b1);
            cpu_read(a ^ 11'h155, 1'b1);
            cpu_read(a, 1'b1);
        end
        pal_cs = 1'b0;
        @(negedge clk);

        // fix 20, A 10, B 10, objects 5
        cpu_write(11'd0, 16'd20, 2'b10, 1'b0);
        cpu_write(11'd1, 16'd10, 2'b10, 1'b0);
        cpu_write(11'd2, 16'd10, 2'b10, 1'b0);
        cpu_write(11'd3, 16'd5, 2'b10, 1'b0);

        // priority read-back
        for (int i = 0; i < `COLMIX_NLAYERS; i++) begin
            cpu_read(i[10:0], 1'b0);
        end
        pcu_cs = 1'b0;
        @(negedge clk);

        add(px(0, 0, 0, 0), px(0, 0, 0, 0), px(0, 0, 0, 0), px(0, 0, 0, 0), 1, 1, 7, 0);
        add(px(0, 0, 3, 4), px(0, 0, 0, 0), px(0, 0, 0, 0), px(0, 0, 0, 0), 1, 1, 7, 0);
        add(px(0, 0, 3, 4), px(0, 0, 9, 2), px(0, 0, 0, 0), px(0, 0, 0, 0), 1, 1, 7, 0);
        add(px(0, 0, 0, 0), px(0, 0, 9, 2), px(0, 0, 17, 11), px(0, 0, 0, 0), 1, 1, 7, 0);
        add(px(0, 0, 3, 4), px(0, 0, 0, 0), px(0, 0, 17, 11), px(0, 0, 0, 0), 1, 1, 7, 0);
        add(px(0, 0, 0, 0), px(0, 0, 9, 2), px(0, 0, 0, 0), px(0, 0, 30, 7), 1, 1, 7, 0);
        add(px(0, 0, 0, 0), px(0, 0, 9, 2), px(0, 0, 0, 0), px(1, 0, 30, 7), 1, 1, 7, 0);
        add(px(0, 0, 3, 4), px(0, 0, 0, 0), px(0, 0, 0, 0), px(2, 0, 30, 7), 1, 1, 7, 0);
        add(px(0, 0, 0, 0), px(0, 0, 0, 0), px(0, 0, 0, 0), px(3, 0, 12, 15), 1, 1, 7, 0);
        // shadow from a losing object
        add(px(0, 0, 0, 0), px(0, 0, 9, 2), px(0, 0, 0, 0), px(3, 1, 12, 15), 1, 1, 7, 1);
        add(px(0, 0, 0, 0), px(0, 0, 9, 2), px(0, 0, 0, 0), px(3, 1, 12, 15), 1, 1, 7, 0);
        add(px(0, 0, 0, 0), px(0, 0, 9, 2), px(0, 0, 0, 0), px(0, 1, 12, 0), 1, 1, 7, 1);
        add(px(0, 0, 3, 4), px(0, 0, 9, 2), px(0, 0, 0, 0), px(0, 0, 0, 0), 0, 1, 7, 0);
        add(px(0, 0, 3, 4), px(0, 0, 9, 2), px(0, 0, 0, 0), px(0, 0, 0, 0), 1, 0, 7, 0);
        for (int d = 0; d < 8; d++) begin
            add(px(0, 0, 5, 9), px(0, 0, 0, 0), px(0, 0, 0, 0), px(0, 1, 1, 3), 1, 1,
                d[2:0], d[0]);
        end

        foreach (tbl[i]) begin
            {fix, lyra, lyrb, obj, lhbl, lvbl, dim, shadow_en} = tbl[i];
            repeat (3) next_strobe();
        end
        repeat (4) next_strobe();

        $display("checks %0d errors %0d", chk.checks, chk.errors);
        if (chk.errors == 0 && chk.checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+common
common/colmix_pkg.sv
logic/colmix_dpram.sv
mixer/colmix_prio.sv
mixer/colmix_palette.sv
mixer/colmix_dimmer.sv
logic/colmix_top.sv
verification/colmix_checker.sv
verification/colmix_tb.sv
